/* logic/dataRam.sv */
`timescale 1ns/1ps

module dataRam #(
    parameter int ramDepthWords = 256,
    parameter int waitStates    = 1
) (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  memPkg::wbMaster_t wb_i,
    output memPkg::wbSlave_t  wb_o
);

    localparam int idxW = (ramDepthWords > 1) ? $clog2(ramDepthWords) : 1;
    localparam int cntW = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

    logic [31:0]     mem [ramDepthWords];
    logic [idxW-1:0] wordIdx;
    logic [cntW-1:0] waitCnt;
    logic            waitDone;
    logic            ackNext;
    logic            ack;
    logic [31:0]     datR;

    // word index wraps at the ram depth
    assign wordIdx  = idxW'(wb_i.adr[31:2] % ramDepthWords);
    assign waitDone = (waitCnt == cntW'(waitStates));
    assign ackNext  = wb_i.cyc && wb_i.stb && !ack && waitDone;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            ack     <= 1'b0;
            waitCnt <= '0;
        end else begin
            ack <= ackNext;
            if (!wb_i.stb || ack || waitDone) begin
                waitCnt <= '0;
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ackNext) begin
            datR <= mem[wordIdx];
        end
        // write lands on the edge that ends the ack cycle
        if (wb_i.cyc && wb_i.stb && wb_i.we && ack) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wb_i.sel[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= wb_i.datW[8*lane +: 8];
                end
            end
        end
    end

    assign wb_o.ack  = ack;
    assign wb_o.datR = datR;

    ackOnlyWithStb: assert property (@(posedge clk_i) disable iff (!rstN_i)
        wb_o.ack |-> wb_i.stb);

endmodule

/* logic/loadAligner.sv */
`timescale 1ns/1ps

module loadAligner (
    input  memPkg::memOp_e op_i,
    input  logic [1:0]     addrLow_i,
    input  logic [31:0]    busData_i,
    output logic [31:0]    loadData_o
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [31:0] extended;

    // byte lane, big-endian order
    always_comb begin
        case (addrLow_i)
            2'b00:   laneByte = busData_i[31:24];
            2'b01:   laneByte = busData_i[23:16];
            2'b10:   laneByte = busData_i[15:8];
            default: laneByte = busData_i[7:0];
        endcase
    end

    // upper half sits at offset 0
    assign laneHalf = addrLow_i[1] ? busData_i[15:0] : busData_i[31:16];

    always_comb begin
        case (op_i)
            memPkg::OP_LB: begin
                extended = {{24{laneByte[7]}}, laneByte};
            end
            memPkg::OP_LBU: begin
                extended = {24'h000000, laneByte};
            end
            memPkg::OP_LH: begin
                extended = {{16{laneHalf[15]}}, laneHalf};
            end
            memPkg::OP_LHU: begin
                extended = {16'h0000, laneHalf};
            end
            default: begin
                extended = busData_i;
            end
        endcase
    end

    // stores and unknown ops give zero
    assign loadData_o = memPkg::isLoad(op_i) ? extended : 32'h00000000;

endmodule

/* logic/memPkg.sv */
package memPkg;

    // MIPS primary opcodes for the memory instructions
    typedef enum logic [5:0] {
        OP_LB  = 6'b100000,
        OP_LH  = 6'b100001,
        OP_LW  = 6'b100011,
        OP_LBU = 6'b100100,
        OP_LHU = 6'b100101,
        OP_SB  = 6'b101000,
        OP_SH  = 6'b101001,
        OP_SW  = 6'b101011
    } memOp_e;

    // request from execute
    typedef struct packed {
        logic        valid;
        memOp_e      op;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [4:0]  destReg;
    } memReq_t;

    // writeback result
    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic        addrErr;
        logic [4:0]  destReg;
        logic [31:0] data;
    } memResult_t;

    // store formatter output, also carries the alignment check
    typedef struct packed {
        logic [3:0]  sel;
        logic [31:0] wdata;
        logic        misaligned;
    } storeFmt_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] datW;
    } wbMaster_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } wbSlave_t;

    function automatic logic isLoad(memOp_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic isStore(memOp_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage

/* logic/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem #(
    parameter int ramDepthWords = 256,
    parameter int waitStates    = 1
) (
    input  logic               clk_i,
    input  logic               rstN_i,
    input  memPkg::memReq_t    req_i,
    output logic               reqReady_o,
    output memPkg::memResult_t result_o
);

    memPkg::storeFmt_t fmt;
    logic [31:0]       loadData;
    memPkg::memOp_e    heldOp;
    logic [1:0]        heldAddrLow;
    memPkg::wbMaster_t wbM;
    memPkg::wbSlave_t  wbS;

    // formatter sees the incoming request, aligner the latched one
    storeFormatter i_storeFormatter (
        .op_i       (req_i.op),
        .addrLow_i  (req_i.addr[1:0]),
        .storeData_i(req_i.storeData),
        .fmt_o      (fmt)
    );

    loadAligner i_loadAligner (
        .op_i      (heldOp),
        .addrLow_i (heldAddrLow),
        .busData_i (wbS.datR),
        .loadData_o(loadData)
    );

    wbAccessCtrl i_wbAccessCtrl (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .req_i        (req_i),
        .reqReady_o   (reqReady_o),
        .fmt_i        (fmt),
        .loadData_i   (loadData),
        .heldOp_o     (heldOp),
        .heldAddrLow_o(heldAddrLow),
        .wb_o         (wbM),
        .wb_i         (wbS),
        .result_o     (result_o)
    );

    dataRam #(
        .ramDepthWords(ramDepthWords),
        .waitStates   (waitStates)
    ) i_dataRam (
        .clk_i (clk_i),
        .rstN_i(rstN_i),
        .wb_i  (wbM),
        .wb_o  (wbS)
    );

endmodule

/* logic/storeFormatter.sv */
`timescale 1ns/1ps

module storeFormatter (
    input  memPkg::memOp_e    op_i,
    input  logic [1:0]        addrLow_i,
    input  logic [31:0]       storeData_i,
    output memPkg::storeFmt_t fmt_o
);

    always_comb begin
        fmt_o.sel        = 4'b0000;
        fmt_o.wdata      = storeData_i;
        fmt_o.misaligned = 1'b0;
        case (op_i)
            memPkg::OP_SW: begin
                fmt_o.sel        = 4'b1111;
                fmt_o.misaligned = (addrLow_i != 2'b00);
            end
            memPkg::OP_SH: begin
                // halfword copied into both halves, lanes picked by bit 1
                fmt_o.wdata      = {storeData_i[15:0], storeData_i[15:0]};
                fmt_o.sel        = addrLow_i[1] ? 4'b0011 : 4'b1100;
                fmt_o.misaligned = addrLow_i[0];
            end
            memPkg::OP_SB: begin
                fmt_o.wdata = {4{storeData_i[7:0]}};
                // big-endian lanes, offset 0 is the top byte
                fmt_o.sel   = 4'b1000 >> addrLow_i;
            end
            memPkg::OP_LW: begin
                fmt_o.misaligned = (addrLow_i != 2'b00);
            end
            memPkg::OP_LH, memPkg::OP_LHU: begin
                fmt_o.misaligned = addrLow_i[0];
            end
            default: ;
        endcase
        // loads always fetch the whole word
        if (memPkg::isLoad(op_i)) begin
            fmt_o.sel = 4'b1111;
        end
    end

endmodule

/* logic/wbAccessCtrl.sv */
`timescale 1ns/1ps

module wbAccessCtrl (
    input  logic               clk_i,
    input  logic               rstN_i,
    input  memPkg::memReq_t    req_i,
    output logic               reqReady_o,
    input  memPkg::storeFmt_t  fmt_i,
    input  logic [31:0]        loadData_i,
    output memPkg::memOp_e     heldOp_o,
    output logic [1:0]         heldAddrLow_o,
    output memPkg::wbMaster_t  wb_o,
    input  memPkg::wbSlave_t   wb_i,
    output memPkg::memResult_t result_o
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        RESPOND
    } state_e;

    state_e         state;
    logic           accept;
    logic           noBus;
    memPkg::memOp_e heldOp;
    logic [31:0]    heldAddr;
    logic [4:0]     heldDest;
    logic [3:0]     heldSel;
    logic [31:0]    heldWdata;
    logic           resValid;
    logic           resRegWrite;
    logic           resAddrErr;
    logic [4:0]     resDest;
    logic [31:0]    resData;

    // a new request can be taken in the result cycle too
    assign reqReady_o = (state != BUS);
    assign accept     = req_i.valid && reqReady_o;
    // misaligned or not a memory op, answered without a bus cycle
    assign noBus = fmt_i.misaligned ||
                   !(memPkg::isLoad(req_i.op) || memPkg::isStore(req_i.op));

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            state    <= IDLE;
            resValid <= 1'b0;
        end else begin
            resValid <= 1'b0;
            case (state)
                BUS: begin
                    if (wb_i.ack) begin
                        state    <= RESPOND;
                        resValid <= 1'b1;
                    end
                end
                default: begin
                    if (accept) begin
                        state    <= noBus ? RESPOND : BUS;
                        resValid <= noBus;
                    end else begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // latched request and result payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            heldOp    <= req_i.op;
            heldAddr  <= req_i.addr;
            heldDest  <= req_i.destReg;
            heldSel   <= fmt_i.sel;
            heldWdata <= fmt_i.wdata;
        end
        if (accept && noBus) begin
            resRegWrite <= 1'b0;
            resAddrErr  <= fmt_i.misaligned;
            resDest     <= req_i.destReg;
            resData     <= 32'h00000000;
        end else if (state == BUS && wb_i.ack) begin
            resRegWrite <= memPkg::isLoad(heldOp);
            resAddrErr  <= 1'b0;
            resDest     <= heldDest;
            resData     <= loadData_i;
        end
    end

    // one cycle per access, cyc and stb together
    assign wb_o.cyc  = (state == BUS);
    assign wb_o.stb  = (state == BUS);
    assign wb_o.we   = memPkg::isStore(heldOp);
    assign wb_o.sel  = heldSel;
    assign wb_o.adr  = {heldAddr[31:2], 2'b00};
    assign wb_o.datW = heldWdata;

    assign heldOp_o      = heldOp;
    assign heldAddrLow_o = heldAddr[1:0];

    assign result_o.valid    = resValid;
    assign result_o.regWrite = resRegWrite;
    assign result_o.addrErr  = resAddrErr;
    assign result_o.destReg  = resDest;
    assign result_o.data     = resData;

    // execute keeps a stalled request steady until it is taken
    reqHeldWhileStalled: assert property (@(posedge clk_i) disable iff (!rstN_i)
        req_i.valid && !reqReady_o |=> req_i.valid && $stable(req_i));

    // master keeps the access steady until the slave answers
    busHeldUntilAck: assert property (@(posedge clk_i) disable iff (!rstN_i)
        wb_o.stb && !wb_i.ack |=> $stable({wb_o.adr, wb_o.we, wb_o.sel, wb_o.datW}));

endmodule

/* memSubsystem.f */
logic/memPkg.sv
logic/storeFormatter.sv
logic/loadAligner.sv
logic/wbAccessCtrl.sv
logic/dataRam.sv
logic/memSubsystem.sv
verification/memSubsystemTb.sv

/* verification/memStimulus.txt */
# columns: op(hex) addr(hex) storeData(hex) destReg(dec) expData(hex) expAddrErr(dec)
# ops: 20 LB, 21 LH, 23 LW, 24 LBU, 25 LHU, 28 SB, 29 SH, 2b SW
2b 00000000 12345678 0 00000000 0
2b 00000004 deadbeef 0 00000000 0
23 00000000 00000000 5 12345678 0
23 00000004 00000000 6 deadbeef 0
2b 00000010 00000000 0 00000000 0
28 00000010 000000a1 0 00000000 0
28 00000011 000000b2 0 00000000 0
28 00000012 000000c3 0 00000000 0
28 00000013 000000d4 0 00000000 0
23 00000010 00000000 7 a1b2c3d4 0
2b 00000020 00000000 0 00000000 0
29 00000020 00001357 0 00000000 0
29 00000022 ffff9bdf 0 00000000 0
23 00000020 00000000 9 13579bdf 0
20 00000010 00000000 10 ffffffa1 0
24 00000010 00000000 11 000000a1 0
20 00000013 00000000 12 ffffffd4 0
24 00000011 00000000 13 000000b2 0
21 00000004 00000000 14 ffffdead 0
25 00000004 00000000 15 0000dead 0
25 00000006 00000000 16 0000beef 0
21 00000020 00000000 17 00001357 0
21 00000022 00000000 18 ffff9bdf 0
23 00000001 00000000 8 00000000 1
29 00000003 0000ffff 0 00000000 1
23 00000000 00000000 19 12345678 0

/* verification/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int ramDepthWords = 256;
    localparam int waitStates    = 1;
    localparam int waitLimit     = 50;

    logic               clk = 1'b0;
    logic               rstN;
    memPkg::memReq_t    req;
    logic               reqReady;
    memPkg::memResult_t result;

    // requests and expected results, one entry per stimulus line
    memPkg::memReq_t reqs[$];
    logic [31:0]     expData[$];
    logic            expErr[$];
    // indices of accepted requests still waiting for a result
    int              pending[$];

    int          reqCount = 0;
    int          resultCount = 0;
    int          validSeen = 0;
    int          mismatchCount = 0;
    int          otherErrCount = 0;
    logic [31:0] lfsrState = 32'h25e51c07;

    memSubsystem #(
        .ramDepthWords(ramDepthWords),
        .waitStates   (waitStates)
    ) i_memSubsystem (
        .clk_i     (clk),
        .rstN_i    (rstN),
        .req_i     (req),
        .reqReady_o(reqReady),
        .result_o  (result)
    );

    always #5 clk = ~clk;

    // every result pulse, also those the collector does not expect
    always @(negedge clk) begin
        if (rstN && result.valid) begin
            validSeen++;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // MIPS loads are 100xxx, stores 101xxx
    function automatic logic opIsLoad(input logic [5:0] op);
        return op[5:3] == 3'b100;
    endfunction

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic pickIdleCycles(output int n);
        lfsrState = lfsrNext(lfsrState);
        n = lfsrState[0];
        lfsrState = lfsrNext(lfsrState);
        n = 2 * n + lfsrState[0];
    endtask

    task automatic loadStimulus();
        int              fd;
        int              n;
        string           line;
        logic [31:0]     opVal;
        logic [31:0]     addr;
        logic [31:0]     sdata;
        logic [31:0]     dest;
        logic [31:0]     data;
        logic [31:0]     err;
        memPkg::memReq_t r;
        fd = $fopen("verification/memStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/memStimulus.txt");
            otherErrCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %d %h %d", opVal, addr, sdata, dest, data, err);
            if (n != 6) begin
                $display("stimulus line could not be parsed: %s", line);
                otherErrCount++;
                continue;
            end
            r.valid     = 1'b1;
            r.op        = memPkg::memOp_e'(opVal[5:0]);
            r.addr      = addr;
            r.storeData = sdata;
            r.destReg   = dest[4:0];
            reqs.push_back(r);
            expData.push_back(data);
            expErr.push_back(err[0]);
        end
        $fclose(fd);
        reqCount = reqs.size();
        if (reqCount == 0) begin
            $display("stimulus file held no requests");
            otherErrCount++;
        end
    endtask

    // request is held until reqReady is seen high, execute style
    task automatic driveAll();
        int idle;
        int waited;
        @(posedge clk);
        for (int i = 0; i < reqCount; i++) begin
            pickIdleCycles(idle);
            if (idle > 0) begin
                req.valid <= 1'b0;
                repeat (idle) @(posedge clk);
            end
            req <= reqs[i];
            waited = 0;
            @(negedge clk);
            while (!reqReady && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!reqReady) begin
                $display("timeout: reqReady stayed low for %0d cycles at request %0d",
                         waitLimit, i);
                otherErrCount++;
                break;
            end
            @(posedge clk);
            pending.push_back(i);
        end
        req.valid <= 1'b0;
    endtask

    task automatic checkResult(input int i);
        checkEqual(result.data, expData[i], $sformatf("request %0d data", i));
        checkEqual(result.addrErr, expErr[i], $sformatf("request %0d addrErr", i));
        checkEqual(result.regWrite, opIsLoad(reqs[i].op) && !expErr[i],
                   $sformatf("request %0d regWrite", i));
        checkEqual(result.destReg, reqs[i].destReg, $sformatf("request %0d destReg", i));
    endtask

    task automatic collectResults();
        int waited;
        int idx;
        while (resultCount < reqCount) begin
            waited = 0;
            @(negedge clk);
            while (!result.valid && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!result.valid) begin
                $display("timeout: no result within %0d cycles, %0d results seen",
                         waitLimit, resultCount);
                otherErrCount++;
                break;
            end
            if (pending.size() == 0) begin
                $display("result arrived with no request outstanding");
                otherErrCount++;
            end else begin
                idx = pending.pop_front();
                checkResult(idx);
            end
            resultCount++;
        end
    endtask

    initial begin
        rstN = 1'b0;
        req  = '0;
        loadStimulus();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkEqual(reqReady, 1'b1, "reqReady after reset");
        checkEqual(result.valid, 1'b0, "result valid after reset");
        fork
            driveAll();
            collectResults();
        join
        // a few more cycles so a stray extra result is counted too
        repeat (4) @(posedge clk);
        checkEqual(validSeen, reqCount, "result pulses against request lines");
        $display("checks done: %0d mismatches, %0d other errors, %0d of %0d results",
                 mismatchCount, otherErrCount, validSeen, reqCount);
        if (mismatchCount == 0 && otherErrCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
